//--- peri_soc.f
+incdir+design
design/peri_soc_pkg.sv
design/bus_access_fsm.sv
design/sys_ctrl.sv
design/core_timer.sv
design/uart_transmitter.sv
design/uart_receiver.sv
design/peri_soc.sv
dv/tb_peri_soc.sv

//--- run_sim.sh
#!/bin/sh
# Builds the peripheral slave testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f peri_soc.f \
  --top-module tb_peri_soc \
  -o sim_peri_soc
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_peri_soc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Everything OK" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- dv/tb_peri_soc.sv
// Table-driven testbench for the peripheral slave, run from the file list by the sim script
`include "peri_soc_settings.svh"

module tb_peri_soc;
  localparam int DRIVE_DELAY = 2;

  typedef enum logic [2:0] {
    OP_READ, OP_WRITE, OP_POLL, OP_RXSEND, OP_TXCHK, OP_TXCOUNT, OP_IRQ, OP_WAITIRQ
  } op_e;
  typedef enum logic [1:0] {CHK_EQ, CHK_ANY, CHK_GE, CHK_LT} chk_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] adr;
    logic [31:0] wdata;
    logic        exp_err;
    chk_e        chk;
    logic [31:0] exp;
    logic        slow;
  } entry_t;

  logic                  clk;
  logic                  resetn;
  peri_soc_pkg::wb_req_t wb_req;
  peri_soc_pkg::wb_rsp_t wb_rsp;
  logic                  uart_rx;
  logic                  uart_tx;
  logic                  timer_irq;

  entry_t     table_q[$];
  logic [7:0] tx_q[$];
  int         errors = 0;
  int         checks = 0;
  int         cur_div = 4;
  int         access_limit = 0;
  int         watchdog_cycles = 0;

  peri_soc dut_i (
    .clk        (clk),
    .resetn     (resetn),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp),
    .uart_rx_i  (uart_rx),
    .uart_tx_o  (uart_tx),
    .timer_irq_o(timer_irq)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic add(input op_e op, input logic [31:0] adr, input logic [31:0] wdata,
                     input logic exp_err, input chk_e chk, input logic [31:0] exp,
                     input logic slow);
    table_q.push_back('{op: op, adr: adr, wdata: wdata, exp_err: exp_err, chk: chk,
                        exp: exp, slow: slow});
  endtask

  // One Wishbone classic cycle that is held until ack or err
  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                           output logic ack, output logic err, output logic [31:0] rdata,
                           output int cycles);
    next_cycle();
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata, sel: 4'hf};
    cycles = 0;
    do begin
      next_cycle();
      cycles++;
    end while (!(wb_rsp.ack || wb_rsp.err) && cycles < access_limit);
    ack   = wb_rsp.ack;
    err   = wb_rsp.err;
    rdata = wb_rsp.dat;
    wb_req = '0;
    checks++;
    assert (ack || err) else begin
      errors++;
      $display("Access to %h got neither ack nor err in %0d cycles", adr, cycles);
    end
  endtask

  task automatic check_data(input entry_t e, input logic [31:0] got);
    logic ok;
    case (e.chk)
      CHK_EQ:  ok = got == e.exp;
      CHK_GE:  ok = got >= e.exp;
      CHK_LT:  ok = got < e.exp;
      default: ok = 1'b1;
    endcase
    checks++;
    assert (ok) else begin
      errors++;
      $display("ERROR wb_rsp_o.dat adr=%h expected %h actual %h", e.adr, e.exp, got);
    end
  endtask

  // Drives one 8N1 frame on the receive line at the current bit period
  task automatic send_rx(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (cur_div) next_cycle();
    end
  endtask

  // Line model that samples each bit of every frame on the transmit line at mid-bit
  initial begin
    logic [7:0] data;
    forever begin
      next_cycle();
      if (resetn && !uart_tx) begin
        repeat (cur_div / 2) next_cycle();
        for (int i = 0; i < 8; i++) begin
          repeat (cur_div) next_cycle();
          data[i] = uart_tx;
        end
        repeat (cur_div) next_cycle();
        checks++;
        assert (uart_tx) else begin
          errors++;
          $display("Transmit frame has a low stop bit");
        end
        // The frame counts as seen once its stop bit has ended
        repeat (cur_div - cur_div / 2) next_cycle();
        tx_q.push_back(data);
      end
    end
  end

  task automatic apply(input entry_t e);
    logic        ack;
    logic        err;
    logic [31:0] rdata;
    logic [7:0]  byte_got;
    int          cycles;
    int          n;
    case (e.op)
      OP_READ, OP_WRITE: begin
        wb_access(e.op == OP_WRITE, e.adr, e.wdata, ack, err, rdata, cycles);
        checks++;
        assert (e.exp_err ? (err && !ack) : (ack && !err)) else begin
          errors++;
          $display("ERROR wb_rsp_o.err adr=%h expected %h actual %h", e.adr, e.exp_err, err);
        end
        if (ack)
          check_data(e, rdata);
        if (e.slow) begin
          checks++;
          assert (cycles >= `RESET_HOLD) else begin
            errors++;
            $display("Access after reboot finished in %0d cycles, before the reset hold", cycles);
          end
        end
        if (e.op == OP_WRITE && ack && e.adr == `DIV_ADDR)
          cur_div = int'(e.wdata[15:0]);
        if (e.op == OP_WRITE && ack && e.adr == `REBOOT_ADDR && e.wdata[15:0] == `REBOOT_MAGIC)
          cur_div = 4;
      end
      OP_POLL: begin
        n = 0;
        do begin
          wb_access(1'b0, e.adr, 32'h0, ack, err, rdata, cycles);
          n++;
        end while ((rdata & e.exp) != e.exp && n < 50);
        check_data(e, rdata & e.exp);
      end
      OP_RXSEND: send_rx(e.wdata[7:0]);
      OP_TXCHK: begin
        n = 0;
        while (tx_q.size() == 0 && n < 20 * cur_div + 100) begin
          next_cycle();
          n++;
        end
        checks++;
        assert (tx_q.size() > 0) else begin
          errors++;
          $display("No frame seen on the transmit line");
        end
        if (tx_q.size() > 0) begin
          byte_got = tx_q.pop_front();
          checks++;
          assert (byte_got == e.exp[7:0]) else begin
            errors++;
            $display("ERROR uart_tx_o expected %h actual %h", e.exp[7:0], byte_got);
          end
        end
      end
      OP_TXCOUNT: begin
        checks++;
        assert (tx_q.size() == int'(e.exp)) else begin
          errors++;
          $display("ERROR tx frames expected %h actual %h", e.exp, tx_q.size());
        end
      end
      OP_IRQ: begin
        next_cycle();
        checks++;
        assert (timer_irq == e.exp[0]) else begin
          errors++;
          $display("ERROR timer_irq_o expected %h actual %h", e.exp[0], timer_irq);
        end
      end
      default: begin
        n = 0;
        while (!timer_irq && n < 2000) begin
          next_cycle();
          n++;
        end
        checks++;
        assert (timer_irq) else begin
          errors++;
          $display("Timer interrupt never rose");
        end
      end
    endcase
  endtask

  initial begin
    logic [31:0] div_val;
    logic [7:0]  rx_byte;
    int          max_div;
    void'($urandom(32'hf259));
    resetn  = 1'b0;
    wb_req  = '0;
    uart_rx = 1'b1;
    div_val = {16'(1 + $urandom % 4), 16'd8};
    rx_byte = 8'($urandom);
    max_div = 8;

    add(OP_READ, `CPU_FREQ_ADDR, 0, 0, CHK_EQ, `SYSTEM_CLK, 0);
    add(OP_READ, `MEM_SIZE_ADDR, 0, 0, CHK_EQ, `MEM_SIZE, 0);
    add(OP_READ, `DIV_ADDR, 0, 0, CHK_EQ, `DIV_RESET, 0);
    add(OP_IRQ, 0, 0, 0, CHK_EQ, 0, 0);
    add(OP_WRITE, `DIV_ADDR, div_val, 0, CHK_ANY, 0, 0);
    add(OP_READ, `DIV_ADDR, 0, 0, CHK_EQ, div_val, 0);
    // Decode of unmatched and faulting addresses
    add(OP_READ, 32'h1000_0020, 0, 0, CHK_EQ, 0, 0);
    add(OP_WRITE, `UART_LSR_ADDR, 32'h55, 0, CHK_EQ, 0, 0);
    add(OP_READ, 32'h2000_0000, 0, 1, CHK_ANY, 0, 0);
    add(OP_READ, 32'h0000_0100, 0, 1, CHK_ANY, 0, 0);
    add(OP_WRITE, `IO_LIMIT, 0, 1, CHK_ANY, 0, 0);
    // Back-to-back transmit where the second write waits for the first frame
    add(OP_WRITE, `UART_DATA_ADDR, 32'hA5, 0, CHK_ANY, 0, 0);
    add(OP_READ, `UART_LSR_ADDR, 0, 0, CHK_EQ, 32'h0, 0);
    add(OP_WRITE, `UART_DATA_ADDR, 32'h3C, 0, CHK_ANY, 0, 0);
    add(OP_TXCOUNT, 0, 0, 0, CHK_EQ, 1, 0);
    add(OP_TXCHK, 0, 0, 0, CHK_EQ, 32'hA5, 0);
    add(OP_TXCHK, 0, 0, 0, CHK_EQ, 32'h3C, 0);
    add(OP_READ, `UART_LSR_ADDR, 0, 0, CHK_EQ, 32'h60, 0);
    add(OP_RXSEND, 0, {24'h0, rx_byte}, 0, CHK_ANY, 0, 0);
    add(OP_POLL, `UART_LSR_ADDR, 0, 0, CHK_EQ, 32'h1, 0);
    add(OP_READ, `UART_DATA_ADDR, 0, 0, CHK_EQ, {24'h0, rx_byte}, 0);
    add(OP_READ, `UART_DATA_ADDR, 0, 0, CHK_EQ, 32'hFFFF_FFFF, 0);
    add(OP_READ, `UART_LSR_ADDR, 0, 0, CHK_EQ, 32'h60, 0);
    // Timer compare and interrupt
    add(OP_WRITE, `TIMER_BASE + `MTIMECMP_HI, 0, 0, CHK_ANY, 0, 0);
    add(OP_WRITE, `TIMER_BASE + `MTIME_HI, 0, 0, CHK_ANY, 0, 0);
    add(OP_WRITE, `TIMER_BASE + `MTIME_LO, 0, 0, CHK_ANY, 0, 0);
    add(OP_WRITE, `TIMER_BASE + `MTIMECMP_LO, 20, 0, CHK_ANY, 0, 0);
    add(OP_WAITIRQ, 0, 0, 0, CHK_ANY, 0, 0);
    add(OP_READ, `TIMER_BASE + `MTIME_LO, 0, 0, CHK_GE, 20, 0);
    add(OP_WRITE, `TIMER_BASE + `MTIMECMP_HI, 32'hFFFF_FFFF, 0, CHK_ANY, 0, 0);
    add(OP_WRITE, `TIMER_BASE + `MTIMECMP_LO, 32'hFFFF_FFFF, 0, CHK_ANY, 0, 0);
    add(OP_IRQ, 0, 0, 0, CHK_EQ, 0, 0);
    // Reboot with the wrong and then the right magic
    add(OP_WRITE, `REBOOT_ADDR, 32'h1234, 0, CHK_ANY, 0, 0);
    add(OP_READ, `DIV_ADDR, 0, 0, CHK_EQ, div_val, 0);
    add(OP_WRITE, `REBOOT_ADDR, {16'h0, `REBOOT_MAGIC}, 0, CHK_ANY, 0, 0);
    add(OP_READ, `DIV_ADDR, 0, 0, CHK_EQ, `DIV_RESET, 1);
    add(OP_READ, `TIMER_BASE + `MTIME_HI, 0, 0, CHK_EQ, 0, 0);
    add(OP_READ, `TIMER_BASE + `MTIME_LO, 0, 0, CHK_LT, 64, 0);

    access_limit    = `RESET_HOLD + 10 * max_div + 200;
    watchdog_cycles = table_q.size() * (10 * max_div + 200) + 3 * (`RESET_HOLD + 8);

    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    resetn = 1'b1;

    foreach (table_q[i])
      apply(table_q[i]);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // Ends a stuck run once the time budget of the whole table is spent
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    errors++;
    $display("Timeout after %0d cycles, the table did not finish", watchdog_cycles);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Something failed");
    $finish;
  end

endmodule

//--- design/peri_soc.sv
// Peripheral slave top level, driven by one Wishbone classic master such as the testbench
module peri_soc (
  input  logic                  clk,
  input  logic                  resetn,
  input  peri_soc_pkg::wb_req_t wb_req_i,
  output peri_soc_pkg::wb_rsp_t wb_rsp_o,
  input  logic                  uart_rx_i,
  output logic                  uart_tx_o,
  output logic                  timer_irq_o
);
  logic                      core_resetn;
  logic                      tx_busy;
  peri_soc_pkg::div_t        div;
  peri_soc_pkg::periph_req_t sys_req;
  peri_soc_pkg::periph_req_t timer_req;
  peri_soc_pkg::periph_req_t utx_req;
  peri_soc_pkg::periph_req_t urx_req;
  peri_soc_pkg::periph_rsp_t sys_rsp;
  peri_soc_pkg::periph_rsp_t timer_rsp;
  peri_soc_pkg::periph_rsp_t utx_rsp;
  peri_soc_pkg::periph_rsp_t urx_rsp;

  bus_access_fsm bus_i (
    .clk        (clk),
    .resetn     (core_resetn),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .sys_req_o  (sys_req),
    .timer_req_o(timer_req),
    .utx_req_o  (utx_req),
    .urx_req_o  (urx_req),
    .sys_rsp_i  (sys_rsp),
    .timer_rsp_i(timer_rsp),
    .utx_rsp_i  (utx_rsp),
    .urx_rsp_i  (urx_rsp)
  );

  // Only this block sees the external reset, the rest runs on the stretched one
  sys_ctrl sys_i (
    .clk          (clk),
    .resetn       (resetn),
    .sys_req_i    (sys_req),
    .sys_rsp_o    (sys_rsp),
    .core_resetn_o(core_resetn),
    .div_o        (div)
  );

  core_timer timer_i (
    .clk        (clk),
    .resetn     (core_resetn),
    .timer_req_i(timer_req),
    .timer_rsp_o(timer_rsp),
    .timer_div_i(div.timer_div),
    .timer_irq_o(timer_irq_o)
  );

  uart_transmitter utx_i (
    .clk       (clk),
    .resetn    (core_resetn),
    .utx_req_i (utx_req),
    .utx_rsp_o (utx_rsp),
    .uart_div_i(div.uart_div),
    .tx_busy_o (tx_busy),
    .uart_tx_o (uart_tx_o)
  );

  uart_receiver urx_i (
    .clk       (clk),
    .resetn    (core_resetn),
    .urx_req_i (urx_req),
    .urx_rsp_o (urx_rsp),
    .uart_div_i(div.uart_div),
    .tx_busy_i (tx_busy),
    .uart_rx_i (uart_rx_i)
  );

endmodule

//--- design/uart_receiver.sv
// UART 8N1 receiver with a one-byte holding register and the line status register
module uart_receiver (
  input  logic                      clk,
  input  logic                      resetn,
  input  peri_soc_pkg::periph_req_t urx_req_i,
  output peri_soc_pkg::periph_rsp_t urx_rsp_o,
  input  logic [15:0]               uart_div_i,
  input  logic                      tx_busy_i,
  input  logic                      uart_rx_i
);
  localparam logic [3:0] OFF_DATA = 4'd0;
  localparam logic [3:0] OFF_LSR  = 4'd1;

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP, RX_FINISH} rx_state_e;

  rx_state_e   state_q;
  logic [1:0]  sync_q;
  logic        rx_s;
  logic [15:0] cnt_q;
  logic [2:0]  bit_cnt;
  logic [7:0]  shift_q;
  logic [7:0]  hold_q;
  logic        full_q;
  logic        half_end;
  logic        bit_end;
  logic        data_rd;

  assign rx_s     = sync_q[1];
  assign half_end = peri_soc_pkg::period_done(cnt_q, {1'b0, uart_div_i[15:1]});
  assign bit_end  = peri_soc_pkg::period_done(cnt_q, uart_div_i);
  assign data_rd  = urx_req_i.valid && !urx_req_i.we && urx_req_i.offset == OFF_DATA;

  // Half a bit finds the middle of the start bit, then whole bits step through the frame
  always_ff @(posedge clk) begin
    if (!resetn) begin
      sync_q  <= 2'b11;
      state_q <= RX_IDLE;
      cnt_q   <= '0;
      bit_cnt <= '0;
      full_q  <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], uart_rx_i};
      cnt_q  <= cnt_q + 16'd1;
      if (data_rd)
        full_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_s)
            state_q <= RX_START;
        end
        RX_START: if (half_end) begin
          cnt_q   <= '0;
          bit_cnt <= '0;
          state_q <= rx_s ? RX_IDLE : RX_DATA;
        end
        RX_DATA: if (bit_end) begin
          cnt_q   <= '0;
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7)
            state_q <= RX_STOP;
        end
        // A low stop bit drops the frame
        RX_STOP: if (bit_end) begin
          cnt_q   <= '0;
          state_q <= rx_s ? RX_FINISH : RX_IDLE;
        end
        RX_FINISH: if (half_end) begin
          full_q  <= 1'b1;
          state_q <= RX_IDLE;
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_end)
      shift_q <= {rx_s, shift_q[7:1]};
    if (state_q == RX_FINISH && half_end)
      hold_q <= shift_q;
  end

  always_comb begin
    urx_rsp_o.ready = urx_req_i.valid;
    if (urx_req_i.offset == OFF_LSR)
      urx_rsp_o.rdata = {25'b0, !tx_busy_i, !tx_busy_i, 4'b0, full_q};
    else
      urx_rsp_o.rdata = full_q ? {24'h0, hold_q} : 32'hFFFF_FFFF;
  end

endmodule

//--- design/uart_transmitter.sv
// UART 8N1 transmitter loaded by a bus write, holding the bus while a frame is on the line
module uart_transmitter (
  input  logic                      clk,
  input  logic                      resetn,
  input  peri_soc_pkg::periph_req_t utx_req_i,
  output peri_soc_pkg::periph_rsp_t utx_rsp_o,
  input  logic [15:0]               uart_div_i,
  output logic                      tx_busy_o,
  output logic                      uart_tx_o
);
  logic        busy_q;
  logic [3:0]  bit_cnt;
  logic [15:0] baud_cnt;
  logic [9:0]  shift_q;
  logic        load;
  logic        bit_end;

  // Ready only when idle, so every accepted write starts a frame
  assign load            = utx_req_i.valid && !busy_q;
  assign utx_rsp_o.ready = load;
  assign utx_rsp_o.rdata = 32'h0;
  assign bit_end         = peri_soc_pkg::period_done(baud_cnt, uart_div_i);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy_q   <= 1'b0;
      bit_cnt  <= '0;
      baud_cnt <= '0;
      shift_q  <= '1;
    end else if (load) begin
      busy_q   <= 1'b1;
      bit_cnt  <= '0;
      baud_cnt <= '0;
      shift_q  <= {1'b1, utx_req_i.wdata[7:0], 1'b0};
    end else if (busy_q) begin
      if (bit_end) begin
        baud_cnt <= '0;
        shift_q  <= {1'b1, shift_q[9:1]};
        bit_cnt  <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd9)
          busy_q <= 1'b0;
      end else begin
        baud_cnt <= baud_cnt + 16'd1;
      end
    end
  end

  // Ones shift in behind the frame, so the line rests high
  assign uart_tx_o = shift_q[0];
  assign tx_busy_o = busy_q;

  a_load_starts_frame: assert property (@(posedge clk) disable iff (!resetn)
    load |-> !busy_q ##1 (busy_q && !uart_tx_o));

endmodule

//--- design/core_timer.sv
// Core-local timer with a prescaled 64-bit mtime, a compare register and the timer interrupt
module core_timer (
  input  logic                      clk,
  input  logic                      resetn,
  input  peri_soc_pkg::periph_req_t timer_req_i,
  output peri_soc_pkg::periph_rsp_t timer_rsp_o,
  input  logic [15:0]               timer_div_i,
  output logic                      timer_irq_o
);
  logic [15:0] pre_cnt;
  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        tick;
  logic        wr;
  logic [31:0] wdata;
  logic [3:0]  bsel;

  assign tick  = peri_soc_pkg::period_done(pre_cnt, timer_div_i);
  assign wr    = timer_req_i.valid && timer_req_i.we;
  assign wdata = timer_req_i.wdata;
  assign bsel  = timer_req_i.sel;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pre_cnt     <= '0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
    end else begin
      pre_cnt <= tick ? 16'd0 : pre_cnt + 16'd1;
      if (tick)
        mtime_q <= mtime_q + 64'd1;
      // A bus write to a word takes priority over the count on that word
      if (wr) begin
        case (timer_req_i.offset)
          4'd0: mtimecmp_q[31:0]  <= peri_soc_pkg::merge_bytes(mtimecmp_q[31:0], wdata, bsel);
          4'd1: mtimecmp_q[63:32] <= peri_soc_pkg::merge_bytes(mtimecmp_q[63:32], wdata, bsel);
          4'd2: mtime_q[31:0]     <= peri_soc_pkg::merge_bytes(mtime_q[31:0], wdata, bsel);
          4'd3: mtime_q[63:32]    <= peri_soc_pkg::merge_bytes(mtime_q[63:32], wdata, bsel);
          default: ;
        endcase
      end
      timer_irq_o <= mtime_q >= mtimecmp_q;
    end
  end

  always_comb begin
    timer_rsp_o.ready = timer_req_i.valid;
    case (timer_req_i.offset)
      4'd0:    timer_rsp_o.rdata = mtimecmp_q[31:0];
      4'd1:    timer_rsp_o.rdata = mtimecmp_q[63:32];
      4'd2:    timer_rsp_o.rdata = mtime_q[31:0];
      4'd3:    timer_rsp_o.rdata = mtime_q[63:32];
      default: timer_rsp_o.rdata = 32'h0;
    endcase
  end

endmodule

//--- design/sys_ctrl.sv
// System control block with the reset stretcher, reboot request, divisor and info registers
`include "peri_soc_settings.svh"

module sys_ctrl (
  input  logic                      clk,
  input  logic                      resetn,
  input  peri_soc_pkg::periph_req_t sys_req_i,
  output peri_soc_pkg::periph_rsp_t sys_rsp_o,
  output logic                      core_resetn_o,
  output peri_soc_pkg::div_t        div_o
);
  localparam logic [3:0] OFF_REBOOT = 4'(`REBOOT_ADDR >> 2);
  localparam logic [3:0] OFF_DIV    = 4'(`DIV_ADDR >> 2);
  localparam logic [3:0] OFF_FREQ   = 4'(`CPU_FREQ_ADDR >> 2);
  localparam logic [3:0] OFF_MEM    = 4'(`MEM_SIZE_ADDR >> 2);

  logic [7:0]         hold_cnt;
  logic               reboot_q;
  logic               reboot_hit;
  peri_soc_pkg::div_t div_q;

  assign reboot_hit = sys_req_i.valid && sys_req_i.we && sys_req_i.offset == OFF_REBOOT &&
                      sys_req_i.wdata[15:0] == `REBOOT_MAGIC;

  // The reboot pulse is delayed by one cycle so the bus can still ack the write
  always_ff @(posedge clk) begin
    if (!resetn) begin
      reboot_q <= 1'b0;
      hold_cnt <= '0;
    end else begin
      reboot_q <= reboot_hit;
      if (reboot_q)
        hold_cnt <= '0;
      else if (!core_resetn_o)
        hold_cnt <= hold_cnt + 8'd1;
    end
  end

  assign core_resetn_o = hold_cnt == 8'(`RESET_HOLD);

  always_ff @(posedge clk) begin
    if (!core_resetn_o)
      div_q <= `DIV_RESET;
    else if (sys_req_i.valid && sys_req_i.we && sys_req_i.offset == OFF_DIV)
      div_q <= peri_soc_pkg::merge_bytes(div_q, sys_req_i.wdata, sys_req_i.sel);
  end

  assign div_o = div_q;

  // Every access completes in its first cycle, writes to read-only words are dropped
  always_comb begin
    sys_rsp_o.ready = sys_req_i.valid;
    case (sys_req_i.offset)
      OFF_DIV:  sys_rsp_o.rdata = div_q;
      OFF_FREQ: sys_rsp_o.rdata = `SYSTEM_CLK;
      OFF_MEM:  sys_rsp_o.rdata = `MEM_SIZE;
      default:  sys_rsp_o.rdata = 32'h0;
    endcase
  end

endmodule

//--- design/bus_access_fsm.sv
// Wishbone classic slave that decodes each access and runs it on one peripheral port
`include "peri_soc_settings.svh"

module bus_access_fsm (
  input  logic                      clk,
  input  logic                      resetn,
  input  peri_soc_pkg::wb_req_t     wb_req_i,
  output peri_soc_pkg::wb_rsp_t     wb_rsp_o,
  output peri_soc_pkg::periph_req_t sys_req_o,
  output peri_soc_pkg::periph_req_t timer_req_o,
  output peri_soc_pkg::periph_req_t utx_req_o,
  output peri_soc_pkg::periph_req_t urx_req_o,
  input  peri_soc_pkg::periph_rsp_t sys_rsp_i,
  input  peri_soc_pkg::periph_rsp_t timer_rsp_i,
  input  peri_soc_pkg::periph_rsp_t utx_rsp_i,
  input  peri_soc_pkg::periph_rsp_t urx_rsp_i
);
  localparam logic [31:0] TIMER_REGION = `TIMER_BASE;

  typedef enum logic [1:0] {IDLE, ACCESS, RESPOND} state_e;

  state_e                    state_q;
  logic                      pending_q;
  peri_soc_pkg::slave_sel_e  sel_q;
  logic                      we_q;
  logic [3:0]                off_q;
  logic [31:0]               wdata_q;
  logic [3:0]                bsel_q;
  logic [31:0]               rdata_q;
  logic                      accept;
  logic                      in_access;
  peri_soc_pkg::periph_req_t base_req;
  peri_soc_pkg::periph_rsp_t sel_rsp;

  function automatic peri_soc_pkg::slave_sel_e decode(input logic [31:0] adr, input logic we);
    if (adr == `UART_DATA_ADDR)
      return we ? peri_soc_pkg::SEL_UART_TX : peri_soc_pkg::SEL_UART_RX;
    if (adr == `UART_LSR_ADDR)
      return we ? peri_soc_pkg::SEL_NONE : peri_soc_pkg::SEL_UART_RX;
    if (adr == `DIV_ADDR || adr == `CPU_FREQ_ADDR || adr == `MEM_SIZE_ADDR || adr == `REBOOT_ADDR)
      return peri_soc_pkg::SEL_SYS;
    if (adr[31:24] == TIMER_REGION[31:24])
      return peri_soc_pkg::SEL_TIMER;
    if (adr >= `IO_BASE && adr < `IO_LIMIT)
      return peri_soc_pkg::SEL_NONE;
    return peri_soc_pkg::SEL_FAULT;
  endfunction

  // Timer registers are packed into word offsets 0 to 3, 15 hits nothing
  function automatic logic [3:0] word_offset(input logic [31:0] adr);
    if (adr[31:24] == TIMER_REGION[31:24]) begin
      if (adr == `TIMER_BASE + `MTIMECMP_LO) return 4'd0;
      if (adr == `TIMER_BASE + `MTIMECMP_HI) return 4'd1;
      if (adr == `TIMER_BASE + `MTIME_LO) return 4'd2;
      if (adr == `TIMER_BASE + `MTIME_HI) return 4'd3;
      return 4'hf;
    end
    return adr[5:2];
  endfunction

  assign accept    = state_q == IDLE && !pending_q && wb_req_i.cyc && wb_req_i.stb;
  assign in_access = state_q == ACCESS;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q   <= IDLE;
      pending_q <= 1'b0;
      sel_q     <= peri_soc_pkg::SEL_NONE;
    end else begin
      case (state_q)
        IDLE: begin
          if (pending_q) begin
            pending_q <= 1'b0;
            state_q   <= ACCESS;
          end else if (accept) begin
            pending_q <= 1'b1;
            sel_q     <= decode(wb_req_i.adr, wb_req_i.we);
          end
        end
        ACCESS: if (sel_rsp.ready) state_q <= RESPOND;
        RESPOND: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      we_q    <= wb_req_i.we;
      off_q   <= word_offset(wb_req_i.adr);
      wdata_q <= wb_req_i.dat;
      bsel_q  <= wb_req_i.sel;
    end
    if (in_access && sel_rsp.ready)
      rdata_q <= sel_rsp.rdata;
  end

  // Unmatched and faulting accesses complete at once with data 0
  always_comb begin
    case (sel_q)
      peri_soc_pkg::SEL_SYS:     sel_rsp = sys_rsp_i;
      peri_soc_pkg::SEL_TIMER:   sel_rsp = timer_rsp_i;
      peri_soc_pkg::SEL_UART_TX: sel_rsp = utx_rsp_i;
      peri_soc_pkg::SEL_UART_RX: sel_rsp = urx_rsp_i;
      default:                   sel_rsp = '{rdata: 32'h0, ready: 1'b1};
    endcase
  end

  assign base_req = '{valid: 1'b0, we: we_q, offset: off_q, wdata: wdata_q, sel: bsel_q};

  always_comb begin
    sys_req_o         = base_req;
    timer_req_o       = base_req;
    utx_req_o         = base_req;
    urx_req_o         = base_req;
    sys_req_o.valid   = in_access && sel_q == peri_soc_pkg::SEL_SYS;
    timer_req_o.valid = in_access && sel_q == peri_soc_pkg::SEL_TIMER;
    utx_req_o.valid   = in_access && sel_q == peri_soc_pkg::SEL_UART_TX;
    urx_req_o.valid   = in_access && sel_q == peri_soc_pkg::SEL_UART_RX;
  end

  assign wb_rsp_o.dat = rdata_q;
  assign wb_rsp_o.ack = state_q == RESPOND && sel_q != peri_soc_pkg::SEL_FAULT;
  assign wb_rsp_o.err = state_q == RESPOND && sel_q == peri_soc_pkg::SEL_FAULT;

  // A response is exclusive and lasts a single cycle
  a_rsp_single: assert property (@(posedge clk) disable iff (!resetn)
    (wb_rsp_o.ack || wb_rsp_o.err) |->
      !(wb_rsp_o.ack && wb_rsp_o.err) ##1 !(wb_rsp_o.ack || wb_rsp_o.err));

  // At most one peripheral sees valid, and only while an access is running
  a_valid_in_access: assert property (@(posedge clk) disable iff (!resetn)
    (sys_req_o.valid || timer_req_o.valid || utx_req_o.valid || urx_req_o.valid) |->
      in_access && $onehot0({sys_req_o.valid, timer_req_o.valid,
                             utx_req_o.valid, urx_req_o.valid}));

endmodule

//--- design/peri_soc_pkg.sv
// Shared bus and peripheral types and helpers for the peripheral slave and its testbench
package peri_soc_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        err;
  } wb_rsp_t;

  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_SYS,
    SEL_TIMER,
    SEL_UART_TX,
    SEL_UART_RX,
    SEL_FAULT
  } slave_sel_e;

  // One access to a single peripheral, offset counted in 32-bit words
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [3:0]  offset;
    logic [31:0] wdata;
    logic [3:0]  sel;
  } periph_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } periph_rsp_t;

  typedef struct packed {
    logic [15:0] timer_div;
    logic [15:0] uart_div;
  } div_t;

  // Byte-lane write into an existing word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  sel);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (sel[i])
        result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  // True on the last cycle of a period, a period of zero acts as one
  function automatic logic period_done(input logic [15:0] count, input logic [15:0] period);
    return ({1'b0, count} + 17'd1) >= {1'b0, period};
  endfunction

endpackage

//--- design/peri_soc_settings.svh
// Address map and build constants for the peripheral slave, included by the RTL and the testbench
`ifndef PERI_SOC_SETTINGS_SVH
`define PERI_SOC_SETTINGS_SVH

// Values reported by the read-only system information registers
`define SYSTEM_CLK     32'd25_000_000
`define MEM_SIZE       32'h0080_0000

// UART data, where a write goes to the transmitter and a read comes from the receiver
`define UART_DATA_ADDR 32'h1000_0000
`define UART_LSR_ADDR  32'h1000_0004
`define DIV_ADDR       32'h1000_0010
`define CPU_FREQ_ADDR  32'h1000_0014
`define MEM_SIZE_ADDR  32'h1000_0018
`define REBOOT_ADDR    32'h1100_0000
`define REBOOT_MAGIC   16'h7777

// Everything in this window that matches no register acks with data 0
`define IO_BASE        32'h1000_0000
`define IO_LIMIT       32'h1200_0000

// Core-local timer region and its register offsets
`define TIMER_BASE     32'h0200_0000
`define MTIMECMP_LO    32'h0000_4000
`define MTIMECMP_HI    32'h0000_4004
`define MTIME_LO       32'h0000_BFF8
`define MTIME_HI       32'h0000_BFFC

`define RESET_HOLD     128
// Timer prescale 1 in the high half, UART bit period 4 in the low half
`define DIV_RESET      32'h0001_0004

`endif
